/* Makefile */
# Verilator flow for the SD card subsystem

VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= tb_sd_subsystem
RTL_TOP   ?= sd_subsystem
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
common/sd_pkg.sv
sd_host/sd_host.sv
source/sd_bus_arbiter.sv
source/sd_block_reader.sv
source/sd_subsystem.sv
dv/sd_card_model.sv
dv/tb_sd_subsystem.sv

/* common/sd_pkg.sv */
// Shared types and constants for the SD card port
// Bus structs, pin bundles and the host register map

package sd_pkg;

	typedef logic [31:0] sd_word_t;
	typedef logic [1:0]  sd_addr_t;
	typedef logic [3:0]  sd_nibble_t;
	typedef logic [7:0]  sd_count_t;	// Block length in dwords

	// Master to host
	typedef struct packed {
		logic     request;
		logic     rw;		// 1 = write
		sd_addr_t addr;
		sd_word_t wdata;
	} sd_bus_req_t;

	// Host to masters
	typedef struct packed {
		sd_word_t rdata;
		logic     ready;
	} sd_bus_rsp_t;

	typedef struct packed {
		logic       clk;
		logic       cmd_dir;
		logic       cmd_out;
		logic       dat_dir;
		sd_nibble_t dat_out;
	} sd_pins_out_t;

	typedef struct packed {
		logic       cmd_in;
		sd_nibble_t dat_in;
	} sd_pins_in_t;

	// Register map
	localparam sd_addr_t SD_REG_PINS  = 2'd0;
	localparam sd_addr_t SD_REG_CMD   = 2'd1;
	localparam sd_addr_t SD_REG_BYTE  = 2'd2;
	localparam sd_addr_t SD_REG_DWORD = 2'd3;

	localparam logic SD_DIR_IN  = 1'b0;
	localparam logic SD_DIR_OUT = 1'b1;

	// Busy lengths of the shifting operations, in system cycles
	localparam int SD_CMD_CYCLES   = 16;
	localparam int SD_BYTE_CYCLES  = 4;
	localparam int SD_DWORD_CYCLES = 16;

endpackage

/* dv/sd_card_model.sv */
// Behavioural SD card
// Counting nibble on DAT, CMD bits captured into a byte register

module sd_card_model (
	input  logic               i_reset,
	input  logic               i_sd_clk,
	input  logic               i_cmd_dir,
	input  logic               i_cmd,
	output logic               o_cmd,
	input  logic               i_dat_dir,
	output sd_pkg::sd_nibble_t o_dat,
	output sd_pkg::sd_nibble_t o_counter,
	output logic [7:0]         o_cmd_byte
);
	import sd_pkg::*;

	sd_nibble_t counter  = '0;
	logic [7:0] cmd_byte = '0;

	// Card advances on every falling SD clock
	always @(negedge i_sd_clk) begin
		if (!i_reset) begin
			counter <= counter + 4'd1;
		end
	end

	// Host changes CMD on the low half, so the rise sees a settled bit
	always @(posedge i_sd_clk) begin
		if (i_cmd_dir == SD_DIR_OUT) begin
			cmd_byte <= {cmd_byte[6:0], i_cmd};
		end
	end

	assign o_cmd      = 1'b1;	// Pulled up, card never answers
	assign o_dat      = (i_dat_dir == SD_DIR_IN) ? counter : '0;
	assign o_counter  = counter;
	assign o_cmd_byte = cmd_byte;

endmodule

/* dv/tb_sd_subsystem.sv */
// Testbench for the SD card subsystem
// Table of register and block operations, checked against a pin and card model

module tb_sd_subsystem;
	import sd_pkg::*;

	typedef enum logic [1:0] {
		OP_READ,
		OP_WRITE,
		OP_BLOCK,
		OP_BLOCK_CPU
	} op_kind_t;

	typedef struct packed {
		op_kind_t  kind;
		logic      rand_data;	// Replace wdata with an xorshift value
		sd_addr_t  addr;
		sd_word_t  wdata;
		sd_count_t count;
		logic      fixed;	// Compare against the expected column
		sd_word_t  expected;
	} op_row_t;

	localparam int NUM_OPS = 23;

	// kind, random, address, wdata, count, fixed, expected
	op_row_t ops [NUM_OPS] = '{
		'{OP_READ,      1'b0, SD_REG_PINS,  32'h0000_0000, 8'd0, 1'b1, 32'h0000_0008},
		'{OP_WRITE,     1'b1, SD_REG_PINS,  32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_READ,      1'b0, SD_REG_PINS,  32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_WRITE,     1'b1, SD_REG_PINS,  32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_READ,      1'b0, SD_REG_PINS,  32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_WRITE,     1'b1, SD_REG_CMD,   32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_READ,      1'b0, SD_REG_PINS,  32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_WRITE,     1'b1, SD_REG_PINS,  32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_READ,      1'b0, SD_REG_BYTE,  32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_READ,      1'b0, SD_REG_DWORD, 32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_READ,      1'b0, SD_REG_PINS,  32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_READ,      1'b0, SD_REG_CMD,   32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_WRITE,     1'b0, SD_REG_BYTE,  32'h0000_FFFF, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_READ,      1'b0, SD_REG_PINS,  32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_WRITE,     1'b1, SD_REG_CMD,   32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_READ,      1'b0, SD_REG_DWORD, 32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_BLOCK,     1'b0, SD_REG_DWORD, 32'h0000_0000, 8'd5, 1'b0, 32'h0000_0000},
		'{OP_BLOCK,     1'b0, SD_REG_DWORD, 32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_WRITE,     1'b0, SD_REG_PINS,  32'h0000_0700, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_BLOCK_CPU, 1'b0, SD_REG_DWORD, 32'h0000_0000, 8'd4, 1'b0, 32'h0000_0000},
		'{OP_READ,      1'b0, SD_REG_CMD,   32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_READ,      1'b0, SD_REG_BYTE,  32'h0000_0000, 8'd0, 1'b0, 32'h0000_0000},
		'{OP_BLOCK,     1'b0, SD_REG_DWORD, 32'h0000_0000, 8'd1, 1'b0, 32'h0000_0000}
	};

	logic       clock = 1'b0;
	logic       reset;
	logic       cpu_request;
	logic       cpu_rw;
	sd_addr_t   cpu_address;
	sd_word_t   cpu_wdata;
	sd_word_t   cpu_rdata;
	logic       cpu_ready;
	logic       block_start;
	sd_count_t  block_count;
	sd_word_t   block_word;
	logic       block_word_valid;
	logic       block_done;
	logic       block_busy;
	logic       sd_clk;
	logic       sd_cmd_dir;
	logic       sd_cmd_out;
	logic       sd_cmd_in;
	logic       sd_dat_dir;
	sd_nibble_t sd_dat_out;
	sd_nibble_t sd_dat_in;
	sd_nibble_t card_count;
	logic [7:0] card_cmd_byte;

	// Expected pin state as the host should hold it
	logic       m_clk     = 1'b0;
	logic       m_cmd_dir = SD_DIR_IN;
	logic       m_dat_dir = SD_DIR_IN;
	logic       m_cmd_out = 1'b0;
	sd_nibble_t m_dat_out = '0;
	sd_word_t   last_rdata = '0;
	sd_word_t   rng = 32'd72;
	int         cycles = 0;
	int         limit = 0;

	always #20 clock = ~clock;

	sd_subsystem u_dut (
		.i_clock            (clock),
		.i_reset            (reset),
		.i_cpu_request      (cpu_request),
		.i_cpu_rw           (cpu_rw),
		.i_cpu_address      (cpu_address),
		.i_cpu_wdata        (cpu_wdata),
		.o_cpu_rdata        (cpu_rdata),
		.o_cpu_ready        (cpu_ready),
		.i_block_start      (block_start),
		.i_block_count      (block_count),
		.o_block_word       (block_word),
		.o_block_word_valid (block_word_valid),
		.o_block_done       (block_done),
		.o_block_busy       (block_busy),
		.o_sd_clk           (sd_clk),
		.o_sd_cmd_dir       (sd_cmd_dir),
		.o_sd_cmd_out       (sd_cmd_out),
		.i_sd_cmd_in        (sd_cmd_in),
		.o_sd_dat_dir       (sd_dat_dir),
		.o_sd_dat_out       (sd_dat_out),
		.i_sd_dat_in        (sd_dat_in)
	);

	sd_card_model u_card (
		.i_reset    (reset),
		.i_sd_clk   (sd_clk),
		.i_cmd_dir  (sd_cmd_dir),
		.i_cmd      (sd_cmd_out),
		.o_cmd      (sd_cmd_in),
		.i_dat_dir  (sd_dat_dir),
		.o_dat      (sd_dat_in),
		.o_counter  (card_count),
		.o_cmd_byte (card_cmd_byte)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string what, input sd_word_t got, input sd_word_t want);
		if (got !== want)
			report_failure($sformatf("FAIL at time %0t: %s, got %h, expected %h",
				$time, what, got, want));
	endtask

	task automatic check_nibble(input string what, input sd_nibble_t got,
			input sd_nibble_t want);
		if (got !== want)
			report_failure($sformatf("FAIL at time %0t: %s, got %h, expected %h",
				$time, what, got, want));
	endtask

	task automatic check_count(input string what, input sd_count_t got,
			input sd_count_t want);
		if (got !== want)
			report_failure($sformatf("FAIL at time %0t: %s, got %0d, expected %0d",
				$time, what, got, want));
	endtask

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles > limit)
			report_failure($sformatf("Timeout: the tests did not finish within %0d cycles",
				limit));
	end

	function automatic sd_word_t next_random(input sd_word_t x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic int max_block_count();
		int m;
		m = 0;
		for (int i = 0; i < NUM_OPS; i++)
			if (int'(ops[i].count) > m)
				m = int'(ops[i].count);
		return m;
	endfunction

	// Lines that are inputs read back what the card drives
	function automatic sd_word_t pin_expect(input sd_nibble_t dat_in);
		sd_nibble_t dat_view;
		logic       cmd_view;
		dat_view = (m_dat_dir == SD_DIR_IN) ? dat_in : m_dat_out;
		cmd_view = (m_cmd_dir == SD_DIR_IN) ? 1'b1 : m_cmd_out;
		return {24'd0, dat_view, cmd_view, m_dat_dir, m_cmd_dir, m_clk};
	endfunction

	function automatic logic [7:0] byte_expect(input sd_nibble_t n);
		return {n, n + 4'd1};	// High nibble arrives first
	endfunction

	function automatic sd_word_t dword_expect(input sd_nibble_t n);
		sd_word_t w;
		for (int k = 0; k < 4; k++)
			w[8 * k +: 8] = byte_expect(n + 4'(2 * k));
		return w;
	endfunction

	task automatic cpu_access(input logic rw, input sd_addr_t addr, input sd_word_t wdata,
			output sd_word_t rdata, output sd_nibble_t cnt);
		@(posedge clock);
		cpu_request <= 1'b1;
		cpu_rw      <= rw;
		cpu_address <= addr;
		cpu_wdata   <= wdata;
		@(negedge clock);
		while (!cpu_ready)
			@(negedge clock);
		rdata = cpu_rdata;
		cnt   = card_count;
		@(posedge clock);
		cpu_request <= 1'b0;
		@(posedge clock);
	endtask

	// Card counter has already passed every sampled nibble when ready shows
	task automatic apply_read(input sd_addr_t addr, input logic fixed,
			input sd_word_t fixed_value);
		sd_word_t   got;
		sd_word_t   want;
		sd_nibble_t cnt;
		cpu_access(1'b0, addr, '0, got, cnt);
		case (addr)
			SD_REG_PINS: want = pin_expect(cnt);
			SD_REG_CMD:  want = last_rdata;	// Invalid read leaves rdata alone
			SD_REG_BYTE: want = {24'd0, byte_expect(cnt - 4'd2)};
			default:     want = dword_expect(cnt - 4'd8);
		endcase
		if (fixed)
			want = fixed_value;
		check_word($sformatf("read of register %0d", addr), got, want);
		last_rdata = got;
		if (addr == SD_REG_BYTE || addr == SD_REG_DWORD) begin
			m_dat_dir = SD_DIR_IN;
			m_clk     = 1'b0;
		end
	endtask

	task automatic write_register(input sd_addr_t addr, input sd_word_t wdata);
		sd_word_t   rdata_ignored;
		sd_nibble_t cnt;
		logic [7:0] mask;
		logic [7:0] value;
		mask  = wdata[15:8];
		value = wdata[7:0];
		cpu_access(1'b1, addr, wdata, rdata_ignored, cnt);
		if (addr == SD_REG_PINS) begin
			m_clk     = mask[0] ? value[0] : m_clk;
			m_cmd_dir = mask[1] ? value[1] : m_cmd_dir;
			m_dat_dir = mask[2] ? value[2] : m_dat_dir;
			m_cmd_out = mask[3] ? value[3] : m_cmd_out;
			for (int b = 0; b < 4; b++)
				if (mask[4 + b])
					m_dat_out[b] = value[4 + b];
		end
		else if (addr == SD_REG_CMD) begin
			check_nibble("command byte high half", card_cmd_byte[7:4], value[7:4]);
			check_nibble("command byte low half", card_cmd_byte[3:0], value[3:0]);
			m_cmd_dir = SD_DIR_OUT;
			m_cmd_out = value[0];	// Last bit shifted out
			m_clk     = 1'b1;
		end
		// Driven pins straight off the top level
		check_word("SD pin outputs", {28'd0, sd_clk, sd_cmd_dir, sd_cmd_out, sd_dat_dir},
			{28'd0, m_clk, m_cmd_dir, m_cmd_out, m_dat_dir});
		check_nibble("DAT output", sd_dat_out, m_dat_out);
	endtask

	task automatic stream_block(input sd_count_t count);
		sd_count_t words;
		logic      finished;
		words    = '0;
		finished = 1'b0;
		@(posedge clock);
		block_start <= 1'b1;
		block_count <= count;
		@(posedge clock);
		block_start <= 1'b0;
		while (!finished) begin
			@(negedge clock);
			if (block_word_valid) begin
				check_word($sformatf("block word %0d", words), block_word,
					dword_expect(card_count - 4'd8));
				last_rdata = block_word;
				words      = words + 8'd1;
			end
			if (block_done)
				finished = 1'b1;
		end
		check_count("block word count", words, count);
		if (count != '0) begin
			m_dat_dir = SD_DIR_IN;
			m_clk     = 1'b0;
		end
	endtask

	// Pin reads that compete with a running block
	task automatic cpu_pin_reads(input int reads);
		for (int i = 0; i < reads; i++) begin
			repeat (7) @(posedge clock);
			apply_read(SD_REG_PINS, 1'b0, '0);
		end
	endtask

	initial begin
		op_row_t  row;
		sd_word_t wdata;
		reset       = 1'b1;
		cpu_request = 1'b0;
		cpu_rw      = 1'b0;
		cpu_address = '0;
		cpu_wdata   = '0;
		block_start = 1'b0;
		block_count = '0;
		limit = NUM_OPS * (SD_DWORD_CYCLES * max_block_count() + 40);
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_word("rdata after reset", cpu_rdata, '0);
		check_word("status after reset",
			{28'd0, cpu_ready, block_word_valid, block_done, block_busy}, '0);

		for (int i = 0; i < NUM_OPS; i++) begin
			row   = ops[i];
			wdata = row.wdata;
			if (row.rand_data) begin
				rng   = next_random(rng);
				wdata = {16'd0, rng[15:0]};
			end
			case (row.kind)
				OP_READ:  apply_read(row.addr, row.fixed, row.expected);
				OP_WRITE: write_register(row.addr, wdata);
				OP_BLOCK: stream_block(row.count);
				default: begin
					fork
						stream_block(row.count);
						cpu_pin_reads(3);
					join
				end
			endcase
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* sd_host/sd_host.sv */
// SD host port
// Bit-banged CMD and DAT pins behind a four-register bus, with a
// command byte shifter and byte/dword readers on DAT

module sd_host (
	input  logic                 i_clock,
	input  logic                 i_reset,
	input  sd_pkg::sd_bus_req_t  i_req,
	output sd_pkg::sd_bus_rsp_t  o_rsp,
	output sd_pkg::sd_pins_out_t o_pins,
	input  sd_pkg::sd_pins_in_t  i_pins
);
	import sd_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CMD,
		ST_BYTE,
		ST_DWORD,
		ST_WAIT_EOT
	} state_t;

	state_t state;

	logic       sd_clk;
	logic       cmd_dir;
	logic       cmd_out;
	logic       dat_dir;
	sd_nibble_t dat_out;

	sd_word_t   rdata;
	logic       ready;

	logic [7:0] cmd_shift;
	logic [3:0] step;	// Half-period counter within a transfer
	logic [3:0] last_step;
	logic [4:0] nib_pos;
	logic [7:0] pin_view;
	logic [7:0] wr_mask;
	logic [7:0] wr_value;

	assign wr_mask  = i_req.wdata[15:8];
	assign wr_value = i_req.wdata[7:0];

	// Pin readback follows the driven value when the line is an output
	assign pin_view = {
		(dat_dir == SD_DIR_IN) ? i_pins.dat_in : dat_out,
		(cmd_dir == SD_DIR_IN) ? i_pins.cmd_in : cmd_out,
		dat_dir,
		cmd_dir,
		sd_clk
	};

	// Nibble k lands high half first, byte k/2 at bits 8*(k/2)
	assign nib_pos = {step[3:2], ~step[1], 2'b00};

	assign last_step = (state == ST_BYTE) ? 4'(SD_BYTE_CYCLES - 1) : 4'(SD_DWORD_CYCLES - 1);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state   <= ST_IDLE;
			sd_clk  <= 1'b0;
			cmd_dir <= SD_DIR_IN;
			cmd_out <= 1'b0;
			dat_dir <= SD_DIR_IN;
			dat_out <= '0;
			rdata   <= '0;
			ready   <= 1'b0;
		end
		else begin
			ready <= 1'b0;

			case (state)
				ST_IDLE: begin
					if (i_req.request) begin
						step <= '0;
						if (!i_req.rw && i_req.addr == SD_REG_BYTE) begin
							rdata   <= '0;
							dat_dir <= SD_DIR_IN;
							sd_clk  <= 1'b0;
							state   <= ST_BYTE;
						end
						else if (!i_req.rw && i_req.addr == SD_REG_DWORD) begin
							rdata   <= '0;
							dat_dir <= SD_DIR_IN;
							sd_clk  <= 1'b0;
							state   <= ST_DWORD;
						end
						else if (i_req.rw && i_req.addr == SD_REG_CMD) begin
							cmd_dir   <= SD_DIR_OUT;
							cmd_shift <= i_req.wdata[7:0];
							state     <= ST_CMD;
						end
						else begin
							// Single-cycle ops; other addresses just complete
							ready <= 1'b1;
							state <= ST_WAIT_EOT;
							if (i_req.addr == SD_REG_PINS) begin
								if (i_req.rw) begin
									sd_clk  <= (sd_clk & ~wr_mask[0]) | (wr_value[0] & wr_mask[0]);
									cmd_dir <= (cmd_dir & ~wr_mask[1]) | (wr_value[1] & wr_mask[1]);
									dat_dir <= (dat_dir & ~wr_mask[2]) | (wr_value[2] & wr_mask[2]);
									cmd_out <= (cmd_out & ~wr_mask[3]) | (wr_value[3] & wr_mask[3]);
									dat_out <= (dat_out & ~wr_mask[7:4]) | (wr_value[7:4] & wr_mask[7:4]);
								end
								else begin
									rdata <= {24'd0, pin_view};
								end
							end
						end
					end
				end

				ST_CMD: begin
					// Data changes on the low half, card samples on the rise
					step <= step + 4'd1;
					if (!step[0]) begin
						sd_clk    <= 1'b0;
						cmd_out   <= cmd_shift[7];
						cmd_shift <= {cmd_shift[6:0], 1'b0};
					end
					else begin
						sd_clk <= 1'b1;
					end
					if (step == 4'(SD_CMD_CYCLES - 1)) begin
						ready <= 1'b1;
						state <= ST_WAIT_EOT;
					end
				end

				ST_BYTE, ST_DWORD: begin
					step <= step + 4'd1;
					if (!step[0]) begin
						sd_clk <= 1'b1;
					end
					else begin
						sd_clk <= 1'b0;
						rdata[nib_pos +: 4] <= i_pins.dat_in;	// Sample before the fall
					end
					if (step == last_step) begin
						ready <= 1'b1;
						state <= ST_WAIT_EOT;
					end
				end

				ST_WAIT_EOT: begin
					ready <= i_req.request;
					if (!i_req.request) begin
						state <= ST_IDLE;
					end
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	assign o_rsp = '{rdata: rdata, ready: ready};

	assign o_pins = '{
		clk:     sd_clk,
		cmd_dir: cmd_dir,
		cmd_out: cmd_out,
		dat_dir: dat_dir,
		dat_out: dat_out
	};

	a_state_legal: assert property (
		@(posedge i_clock) disable iff (i_reset)
		state inside {ST_IDLE, ST_CMD, ST_BYTE, ST_DWORD, ST_WAIT_EOT}
	);

	// No spurious response out of idle
	a_no_idle_ready: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(state == ST_IDLE && !i_req.request) |=> !o_rsp.ready
	);

endmodule

/* source/sd_block_reader.sv */
// SD block reader
// Streams a run of DAT dwords through the host, one strobe per word

module sd_block_reader (
	input  logic                i_clock,
	input  logic                i_reset,
	input  logic                i_start,
	input  sd_pkg::sd_count_t   i_count,
	output sd_pkg::sd_bus_req_t o_req,
	input  sd_pkg::sd_bus_rsp_t i_rsp,
	output sd_pkg::sd_word_t    o_word,
	output logic                o_word_valid,
	output logic                o_done,
	output logic                o_busy
);
	import sd_pkg::*;

	logic      busy;
	logic      request;
	sd_count_t remaining;	// Words still to fetch
	sd_word_t  word;
	logic      word_valid;
	logic      done;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy       <= 1'b0;
			request    <= 1'b0;
			word_valid <= 1'b0;
			done       <= 1'b0;
		end
		else begin
			word_valid <= 1'b0;
			done       <= 1'b0;

			if (!busy) begin
				if (i_start) begin
					if (i_count == '0) begin
						done <= 1'b1;
					end
					else begin
						busy      <= 1'b1;
						request   <= 1'b1;
						remaining <= i_count;
					end
				end
			end
			else if (request) begin
				if (i_rsp.ready) begin
					word       <= i_rsp.rdata;
					word_valid <= 1'b1;
					request    <= 1'b0;
					remaining  <= remaining - 8'd1;
				end
			end
			else if (remaining == '0) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			else begin
				request <= 1'b1;	// Next dword after a one-cycle gap
			end
		end
	end

	assign o_req = '{
		request: request,
		rw:      1'b0,
		addr:    SD_REG_DWORD,
		wdata:   '0
	};

	assign o_word       = word;
	assign o_word_valid = word_valid;
	assign o_done       = done;
	assign o_busy       = busy;

endmodule

/* source/sd_bus_arbiter.sv */
// SD register bus arbiter
// Fixed priority, CPU first; a grant lasts for one whole transaction

module sd_bus_arbiter (
	input  logic                i_clock,
	input  logic                i_reset,
	input  sd_pkg::sd_bus_req_t i_cpu_req,
	input  sd_pkg::sd_bus_req_t i_blk_req,
	output sd_pkg::sd_bus_rsp_t o_cpu_rsp,
	output sd_pkg::sd_bus_rsp_t o_blk_rsp,
	output sd_pkg::sd_bus_req_t o_host_req,
	input  sd_pkg::sd_bus_rsp_t i_host_rsp
);
	import sd_pkg::*;

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_CPU,
		OWN_BLK
	} owner_t;

	owner_t owner;
	logic   ready_seen;	// Owner has had its response
	logic   owner_request;

	always_comb begin
		case (owner)
			OWN_CPU: begin
				owner_request = i_cpu_req.request;
				o_host_req    = i_cpu_req;
			end
			OWN_BLK: begin
				owner_request = i_blk_req.request;
				o_host_req    = i_blk_req;
			end
			default: begin
				owner_request = 1'b0;
				o_host_req    = '0;	// Idle bus
			end
		endcase
	end

	assign o_cpu_rsp = '{rdata: i_host_rsp.rdata, ready: i_host_rsp.ready && owner == OWN_CPU};
	assign o_blk_rsp = '{rdata: i_host_rsp.rdata, ready: i_host_rsp.ready && owner == OWN_BLK};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			owner      <= OWN_NONE;
			ready_seen <= 1'b0;
		end
		else if (owner == OWN_NONE) begin
			ready_seen <= 1'b0;
			if (i_cpu_req.request)
				owner <= OWN_CPU;
			else if (i_blk_req.request)
				owner <= OWN_BLK;
		end
		else begin
			if (i_host_rsp.ready)
				ready_seen <= 1'b1;
			if (ready_seen && !owner_request)
				owner <= OWN_NONE;	// Transaction over
		end
	end

	a_grant_held: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(owner != OWN_NONE && owner_request) |=> $stable(owner)
	);

endmodule

/* source/sd_subsystem.sv */
// SD card subsystem
// CPU register port and block reader sharing one SD host

module sd_subsystem (
	input  logic               i_clock,
	input  logic               i_reset,
	input  logic               i_cpu_request,
	input  logic               i_cpu_rw,
	input  sd_pkg::sd_addr_t   i_cpu_address,
	input  sd_pkg::sd_word_t   i_cpu_wdata,
	output sd_pkg::sd_word_t   o_cpu_rdata,
	output logic               o_cpu_ready,
	input  logic               i_block_start,
	input  sd_pkg::sd_count_t  i_block_count,
	output sd_pkg::sd_word_t   o_block_word,
	output logic               o_block_word_valid,
	output logic               o_block_done,
	output logic               o_block_busy,
	output logic               o_sd_clk,
	output logic               o_sd_cmd_dir,
	output logic               o_sd_cmd_out,
	input  logic               i_sd_cmd_in,
	output logic               o_sd_dat_dir,
	output sd_pkg::sd_nibble_t o_sd_dat_out,
	input  sd_pkg::sd_nibble_t i_sd_dat_in
);
	import sd_pkg::*;

	sd_bus_req_t  cpu_req;
	sd_bus_rsp_t  cpu_rsp;
	sd_bus_req_t  blk_req;
	sd_bus_rsp_t  blk_rsp;
	sd_bus_req_t  host_req;
	sd_bus_rsp_t  host_rsp;
	sd_pins_out_t pins_out;
	sd_pins_in_t  pins_in;

	assign cpu_req = '{
		request: i_cpu_request,
		rw:      i_cpu_rw,
		addr:    i_cpu_address,
		wdata:   i_cpu_wdata
	};
	assign o_cpu_rdata = cpu_rsp.rdata;
	assign o_cpu_ready = cpu_rsp.ready;

	assign pins_in      = '{cmd_in: i_sd_cmd_in, dat_in: i_sd_dat_in};
	assign o_sd_clk     = pins_out.clk;
	assign o_sd_cmd_dir = pins_out.cmd_dir;
	assign o_sd_cmd_out = pins_out.cmd_out;
	assign o_sd_dat_dir = pins_out.dat_dir;
	assign o_sd_dat_out = pins_out.dat_out;

	sd_bus_arbiter u_arbiter (
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_cpu_req  (cpu_req),
		.i_blk_req  (blk_req),
		.o_cpu_rsp  (cpu_rsp),
		.o_blk_rsp  (blk_rsp),
		.o_host_req (host_req),
		.i_host_rsp (host_rsp)
	);

	sd_block_reader u_block_reader (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_start      (i_block_start),
		.i_count      (i_block_count),
		.o_req        (blk_req),
		.i_rsp        (blk_rsp),
		.o_word       (o_block_word),
		.o_word_valid (o_block_word_valid),
		.o_done       (o_block_done),
		.o_busy       (o_block_busy)
	);

	sd_host u_host (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_req   (host_req),
		.o_rsp   (host_rsp),
		.o_pins  (pins_out),
		.i_pins  (pins_in)
	);

endmodule
